// File: source/gps_macros.svh
`ifndef GPS_MACROS_SVH
`define GPS_MACROS_SVH

// Sample and accumulator widths.
`define SAMPLE_W     2
`define ACC_W        16

// Loop state widths.
`define DPHI_W       24
`define TAU_W        12

// I^2 + Q^2 of two full-scale sums fits in 2*ACC_W+1 bits.
`define PWR_W        33

// Spreading code generator.
`define PRN_W        5
`define LFSR_W       10

// Valid samples per dump.
`define DUMP_LEN     64

// Carrier increment step per dump.
`define CARRIER_STEP 16

// Tracking memory entries.
`define MEM_DEPTH    4

`endif

// File: source/gps_pkg.sv
`include "gps_macros.svh"

package gps_pkg;

   // Signed correlator sum.
   typedef logic signed [`ACC_W-1:0] acc_t;

   // Tracking memory address.
   typedef logic [$clog2(`MEM_DEPTH)-1:0] mem_addr_t;

   // One tracking memory entry.
   // Tag first, then carrier increment, then code offset.
   typedef struct packed {
      logic [1:0]               tag;
      logic [`DPHI_W-1:0]       carrier_dphi;
      logic signed [`TAU_W-1:0] tau;
   } track_rec_t;

endpackage

// File: source/sample_sync.sv
`timescale 1ns/1ns
`include "gps_macros.svh"

module sample_sync (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_clk_sample,
   input  logic                        i_sample_valid,
   input  logic signed [`SAMPLE_W-1:0] i_data_i,
   input  logic signed [`SAMPLE_W-1:0] i_data_q,
   output logic                        o_data_available,
   output logic signed [`SAMPLE_W-1:0] o_data_i,
   output logic signed [`SAMPLE_W-1:0] o_data_q
);

   logic [1:0] sync_q;
   logic       sync_prev;
   logic       sample_edge;
   logic [1:0] hold_dly;

   // Rising edge of the synchronized sample clock.
   assign sample_edge = sync_q[1] & ~sync_prev;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         sync_q           <= '0;
         sync_prev        <= 1'b0;
         hold_dly         <= '0;
         o_data_available <= 1'b0;
      end else begin
         // Two-flop synchronizer.
         sync_q    <= {sync_q[0], i_clk_sample};
         sync_prev <= sync_q[1];
         // Give the sample bits two cycles to settle.
         hold_dly  <= {hold_dly[0], sample_edge};
         o_data_available <= hold_dly[1] & i_sample_valid;
      end
   end

   // Sample held until the next strobe.
   always_ff @(posedge clk) begin
      if (hold_dly[1]) begin
         o_data_i <= i_data_i;
         o_data_q <= i_data_q;
      end
   end

endmodule

// File: source/code_gen.sv
`timescale 1ns/1ns
`include "gps_macros.svh"

module code_gen (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_load,
   input  logic [`PRN_W-1:0] i_prn,
   input  logic              i_advance,
   output logic              o_early,
   output logic              o_prompt,
   output logic              o_late
);

   logic [`LFSR_W-1:0] lfsr;
   logic [`LFSR_W-1:0] seed;
   logic               feedback;
   logic               late_q;

   // An all-zero state would lock up the register.
   assign seed = (i_prn == '0) ? `LFSR_W'(1) : `LFSR_W'(i_prn);

   // Fibonacci form, taps 10 and 3.
   assign feedback = lfsr[`LFSR_W-1] ^ lfsr[2];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         lfsr   <= `LFSR_W'(1);
         late_q <= 1'b0;
      end else if (i_load) begin
         lfsr   <= seed;
         late_q <= 1'b0;
      end else if (i_advance) begin
         lfsr   <= {lfsr[`LFSR_W-2:0], feedback};
         late_q <= lfsr[`LFSR_W-1];
      end
   end

   // Output bit is the MSB; the bit below it comes out next.
   assign o_prompt = lfsr[`LFSR_W-1];
   assign o_early  = lfsr[`LFSR_W-2];
   assign o_late   = late_q;

endmodule

// File: source/correlator_channel.sv
`timescale 1ns/1ns
`include "gps_macros.svh"

module correlator_channel (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_data_available,
   input  logic signed [`SAMPLE_W-1:0] i_data_i,
   input  logic signed [`SAMPLE_W-1:0] i_data_q,
   input  logic                        i_init,
   input  logic [`PRN_W-1:0]           i_prn,
   input  logic [`DPHI_W-1:0]          i_init_carrier_dphi,
   input  logic                        i_mem_gnt,
   output logic                        o_init_track,
   output logic [`DPHI_W-1:0]          o_init_carrier_dphi,
   output logic                        o_acc_valid,
   output logic [1:0]                  o_acc_tag,
   output gps_pkg::acc_t               o_i_early,
   output gps_pkg::acc_t               o_q_early,
   output gps_pkg::acc_t               o_i_prompt,
   output gps_pkg::acc_t               o_q_prompt,
   output gps_pkg::acc_t               o_i_late,
   output gps_pkg::acc_t               o_q_late,
   output logic                        o_mem_req,
   output gps_pkg::mem_addr_t          o_mem_addr,
   output gps_pkg::track_rec_t         o_mem_data
);

   localparam int CNT_W = $clog2(`DUMP_LEN);

   logic             active;
   logic [CNT_W-1:0] sample_cnt;
   logic [1:0]       tag_cnt;
   logic             take;
   logic             dump;
   logic             chip_early;
   logic             chip_prompt;
   logic             chip_late;
   gps_pkg::acc_t    acc_ie, acc_qe, acc_ip, acc_qp, acc_il, acc_ql;
   gps_pkg::acc_t    nxt_ie, nxt_qe, nxt_ip, nxt_qp, nxt_il, nxt_ql;

   // Chip 1 is +1, chip 0 is -1.
   function automatic gps_pkg::acc_t chip_term(input logic chip,
                                               input logic signed [`SAMPLE_W-1:0] x);
      gps_pkg::acc_t ext;
      ext = gps_pkg::acc_t'(x);
      return chip ? ext : -ext;
   endfunction

   // Samples are ignored until the first init.
   assign take = active & i_data_available & ~i_init;
   assign dump = take && (sample_cnt == CNT_W'(`DUMP_LEN - 1));

   code_gen u_code_gen (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_load    (i_init),
      .i_prn     (i_prn),
      .i_advance (take),
      .o_early   (chip_early),
      .o_prompt  (chip_prompt),
      .o_late    (chip_late)
   );

   always_comb begin
      nxt_ie = acc_ie + chip_term(chip_early, i_data_i);
      nxt_qe = acc_qe + chip_term(chip_early, i_data_q);
      nxt_ip = acc_ip + chip_term(chip_prompt, i_data_i);
      nxt_qp = acc_qp + chip_term(chip_prompt, i_data_q);
      nxt_il = acc_il + chip_term(chip_late, i_data_i);
      nxt_ql = acc_ql + chip_term(chip_late, i_data_q);
   end

   ////////////////////
   // Control
   ////////////////////

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         active       <= 1'b0;
         sample_cnt   <= '0;
         tag_cnt      <= '0;
         o_acc_valid  <= 1'b0;
         o_init_track <= 1'b0;
         o_mem_req    <= 1'b0;
      end else begin
         o_acc_valid  <= dump;
         o_init_track <= i_init;
         if (i_init) begin
            active     <= 1'b1;
            sample_cnt <= '0;
            tag_cnt    <= '0;
         end else if (take) begin
            sample_cnt <= dump ? '0 : sample_cnt + 1'b1;
            if (dump) begin
               tag_cnt <= tag_cnt + 1'b1;
            end
         end
         // Init record request, held until granted.
         if (i_init) begin
            o_mem_req <= 1'b1;
         end else if (i_mem_gnt) begin
            o_mem_req <= 1'b0;
         end
      end
   end

   ////////////////////
   // Accumulation
   ////////////////////

   always_ff @(posedge clk) begin
      if (i_init) begin
         acc_ie <= '0;
         acc_qe <= '0;
         acc_ip <= '0;
         acc_qp <= '0;
         acc_il <= '0;
         acc_ql <= '0;
         o_init_carrier_dphi <= i_init_carrier_dphi;
      end else if (dump) begin
         acc_ie <= '0;
         acc_qe <= '0;
         acc_ip <= '0;
         acc_qp <= '0;
         acc_il <= '0;
         acc_ql <= '0;
         o_i_early  <= nxt_ie;
         o_q_early  <= nxt_qe;
         o_i_prompt <= nxt_ip;
         o_q_prompt <= nxt_qp;
         o_i_late   <= nxt_il;
         o_q_late   <= nxt_ql;
         o_acc_tag  <= tag_cnt;
      end else if (take) begin
         acc_ie <= nxt_ie;
         acc_qe <= nxt_qe;
         acc_ip <= nxt_ip;
         acc_qp <= nxt_qp;
         acc_il <= nxt_il;
         acc_ql <= nxt_ql;
      end
   end

   // Init record always lands in entry 0.
   assign o_mem_addr = '0;
   assign o_mem_data = '{tag: 2'd0, carrier_dphi: o_init_carrier_dphi, tau: '0};

endmodule

// File: source/tracking_loops.sv
`timescale 1ns/1ns
`include "gps_macros.svh"

module tracking_loops (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_init,
   input  logic [`DPHI_W-1:0]        i_init_carrier_dphi,
   input  logic                      i_acc_valid,
   input  logic [1:0]                i_acc_tag,
   input  gps_pkg::acc_t             i_i_early,
   input  gps_pkg::acc_t             i_q_early,
   input  gps_pkg::acc_t             i_i_prompt,
   input  gps_pkg::acc_t             i_q_prompt,
   input  gps_pkg::acc_t             i_i_late,
   input  gps_pkg::acc_t             i_q_late,
   input  logic                      i_track_carrier_en,
   input  logic                      i_track_code_en,
   input  logic                      i_mem_gnt,
   output logic                      o_mem_req,
   output gps_pkg::mem_addr_t        o_mem_addr,
   output gps_pkg::track_rec_t       o_mem_data,
   output logic                      o_tracking_ready,
   output logic [`PWR_W-1:0]         o_i2q2_early,
   output logic [`PWR_W-1:0]         o_i2q2_prompt,
   output logic [`PWR_W-1:0]         o_i2q2_late,
   output logic [`DPHI_W-1:0]        o_carrier_dphi,
   output logic signed [`TAU_W-1:0]  o_tau_prime
);

   logic                       calc_q;
   logic [`DPHI_W-1:0]         dphi_q, dphi_nxt;
   logic signed [`TAU_W-1:0]   tau_q, tau_nxt;
   logic [`PWR_W-1:0]          pwr_e, pwr_p, pwr_l;
   logic signed [2*`ACC_W-1:0] prompt_prod;
   gps_pkg::track_rec_t        rec_q;

   function automatic logic [`PWR_W-1:0] power(input gps_pkg::acc_t re,
                                               input gps_pkg::acc_t im);
      logic signed [2*`ACC_W-1:0] re_sq;
      logic signed [2*`ACC_W-1:0] im_sq;
      re_sq = re * re;
      im_sq = im * im;
      return `PWR_W'($unsigned(re_sq)) + `PWR_W'($unsigned(im_sq));
   endfunction

   ////////////////////
   // Discriminators
   ////////////////////

   always_comb begin
      pwr_e = power(i_i_early, i_q_early);
      pwr_p = power(i_i_prompt, i_q_prompt);
      pwr_l = power(i_i_late, i_q_late);
      prompt_prod = i_i_prompt * i_q_prompt;

      // Carrier steps by the sign of I*Q on the prompt tap.
      dphi_nxt = dphi_q;
      if (i_track_carrier_en) begin
         if (prompt_prod > 0) begin
            dphi_nxt = dphi_q + `DPHI_W'(`CARRIER_STEP);
         end else if (prompt_prod < 0) begin
            dphi_nxt = dphi_q - `DPHI_W'(`CARRIER_STEP);
         end
      end

      // Code offset moves toward the stronger side.
      tau_nxt = tau_q;
      if (i_track_code_en) begin
         if (pwr_e > pwr_l) begin
            tau_nxt = tau_q - `TAU_W'(1);
         end else if (pwr_l > pwr_e) begin
            tau_nxt = tau_q + `TAU_W'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         calc_q    <= 1'b0;
         dphi_q    <= '0;
         tau_q     <= '0;
         o_mem_req <= 1'b0;
      end else begin
         calc_q <= i_acc_valid;
         if (i_init) begin
            dphi_q <= i_init_carrier_dphi;
            tau_q  <= '0;
         end else if (calc_q) begin
            dphi_q <= dphi_nxt;
            tau_q  <= tau_nxt;
         end
         // Result request waits out any channel write.
         if (calc_q) begin
            o_mem_req <= 1'b1;
         end else if (i_mem_gnt) begin
            o_mem_req <= 1'b0;
         end
      end
   end

   // Result record, held stable while the request is pending.
   always_ff @(posedge clk) begin
      if (calc_q) begin
         o_i2q2_early  <= pwr_e;
         o_i2q2_prompt <= pwr_p;
         o_i2q2_late   <= pwr_l;
         o_mem_addr    <= gps_pkg::mem_addr_t'(i_acc_tag);
         rec_q         <= '{tag: i_acc_tag, carrier_dphi: dphi_nxt, tau: tau_nxt};
      end
   end

   assign o_mem_data       = rec_q;
   assign o_carrier_dphi   = rec_q.carrier_dphi;
   assign o_tau_prime      = rec_q.tau;
   assign o_tracking_ready = o_mem_req & i_mem_gnt;

endmodule

// File: source/track_mem_arbiter.sv
`timescale 1ns/1ns
`include "gps_macros.svh"

module track_mem_arbiter (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_ch_req,
   input  gps_pkg::mem_addr_t  i_ch_addr,
   input  gps_pkg::track_rec_t i_ch_data,
   input  logic                i_lp_req,
   input  gps_pkg::mem_addr_t  i_lp_addr,
   input  gps_pkg::track_rec_t i_lp_data,
   input  gps_pkg::mem_addr_t  i_rd_addr,
   output logic                o_ch_gnt,
   output logic                o_lp_gnt,
   output gps_pkg::track_rec_t o_rd_data
);

   gps_pkg::track_rec_t mem [`MEM_DEPTH];

   ////////////////////
   // Grant
   ////////////////////

   // Channel first; the loops hold their request until free.
   assign o_ch_gnt = i_ch_req;
   assign o_lp_gnt = i_lp_req & ~i_ch_req;

   ////////////////////
   // Storage
   ////////////////////

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int k = 0; k < `MEM_DEPTH; k++) begin
            mem[k] <= '0;
         end
      end else if (o_ch_gnt) begin
         mem[i_ch_addr] <= i_ch_data;
      end else if (o_lp_gnt) begin
         mem[i_lp_addr] <= i_lp_data;
      end
   end

   // Asynchronous read port.
   assign o_rd_data = mem[i_rd_addr];

endmodule

// File: source/gps_track_top.sv
`timescale 1ns/1ns
`include "gps_macros.svh"

module gps_track_top (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_clk_sample,
   input  logic                        i_sample_valid,
   input  logic signed [`SAMPLE_W-1:0] i_data_i,
   input  logic signed [`SAMPLE_W-1:0] i_data_q,
   input  logic                        i_init,
   input  logic [`PRN_W-1:0]           i_prn,
   input  logic [`DPHI_W-1:0]          i_init_carrier_dphi,
   input  logic                        i_track_carrier_en,
   input  logic                        i_track_code_en,
   input  gps_pkg::mem_addr_t          i_rd_addr,
   output logic                        o_acc_valid,
   output logic [1:0]                  o_acc_tag,
   output gps_pkg::acc_t               o_i_early,
   output gps_pkg::acc_t               o_q_early,
   output gps_pkg::acc_t               o_i_prompt,
   output gps_pkg::acc_t               o_q_prompt,
   output gps_pkg::acc_t               o_i_late,
   output gps_pkg::acc_t               o_q_late,
   output logic                        o_tracking_ready,
   output logic [`PWR_W-1:0]           o_i2q2_early,
   output logic [`PWR_W-1:0]           o_i2q2_prompt,
   output logic [`PWR_W-1:0]           o_i2q2_late,
   output logic [`DPHI_W-1:0]          o_carrier_dphi,
   output logic signed [`TAU_W-1:0]    o_tau_prime,
   output gps_pkg::track_rec_t         o_rd_data
);

   logic                        data_available;
   logic signed [`SAMPLE_W-1:0] data_i;
   logic signed [`SAMPLE_W-1:0] data_q;
   logic                        init_track;
   logic [`DPHI_W-1:0]          init_carrier_dphi;
   logic                        ch_req, ch_gnt;
   gps_pkg::mem_addr_t          ch_addr;
   gps_pkg::track_rec_t         ch_data;
   logic                        lp_req, lp_gnt;
   gps_pkg::mem_addr_t          lp_addr;
   gps_pkg::track_rec_t         lp_data;

   // Sample clock crossing.
   sample_sync u_sample_sync (
      .clk(clk), .i_rst_n(i_rst_n), .i_clk_sample(i_clk_sample),
      .i_sample_valid(i_sample_valid), .i_data_i(i_data_i), .i_data_q(i_data_q),
      .o_data_available(data_available), .o_data_i(data_i), .o_data_q(data_q)
   );

   correlator_channel u_channel (
      .clk(clk), .i_rst_n(i_rst_n), .i_data_available(data_available),
      .i_data_i(data_i), .i_data_q(data_q), .i_init(i_init), .i_prn(i_prn),
      .i_init_carrier_dphi(i_init_carrier_dphi), .i_mem_gnt(ch_gnt),
      .o_init_track(init_track), .o_init_carrier_dphi(init_carrier_dphi),
      .o_acc_valid(o_acc_valid), .o_acc_tag(o_acc_tag),
      .o_i_early(o_i_early), .o_q_early(o_q_early),
      .o_i_prompt(o_i_prompt), .o_q_prompt(o_q_prompt),
      .o_i_late(o_i_late), .o_q_late(o_q_late),
      .o_mem_req(ch_req), .o_mem_addr(ch_addr), .o_mem_data(ch_data)
   );

   tracking_loops u_loops (
      .clk(clk), .i_rst_n(i_rst_n), .i_init(init_track),
      .i_init_carrier_dphi(init_carrier_dphi), .i_acc_valid(o_acc_valid),
      .i_acc_tag(o_acc_tag), .i_i_early(o_i_early), .i_q_early(o_q_early),
      .i_i_prompt(o_i_prompt), .i_q_prompt(o_q_prompt),
      .i_i_late(o_i_late), .i_q_late(o_q_late),
      .i_track_carrier_en(i_track_carrier_en), .i_track_code_en(i_track_code_en),
      .i_mem_gnt(lp_gnt), .o_mem_req(lp_req), .o_mem_addr(lp_addr),
      .o_mem_data(lp_data), .o_tracking_ready(o_tracking_ready),
      .o_i2q2_early(o_i2q2_early), .o_i2q2_prompt(o_i2q2_prompt),
      .o_i2q2_late(o_i2q2_late), .o_carrier_dphi(o_carrier_dphi),
      .o_tau_prime(o_tau_prime)
   );

   // Shared tracking memory.
   track_mem_arbiter u_arbiter (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_ch_req(ch_req), .i_ch_addr(ch_addr), .i_ch_data(ch_data),
      .i_lp_req(lp_req), .i_lp_addr(lp_addr), .i_lp_data(lp_data),
      .i_rd_addr(i_rd_addr), .o_ch_gnt(ch_gnt), .o_lp_gnt(lp_gnt),
      .o_rd_data(o_rd_data)
   );

endmodule

// File: verif/gps_track_tb.sv
`timescale 1ns/1ns
`include "gps_macros.svh"

module gps_track_tb;

   localparam int CLK_PERIOD      = 8;
   localparam int HALF_SAMPLE     = 6;
   localparam int INIT_CYCLE      = 7;
   localparam int WATCHDOG_CYCLES = 12 * `DUMP_LEN * 6 * 2 + 4000;

   typedef struct packed {
      logic [1:0] tag;
      int         ie, qe, ip, qp, il, ql;
   } dump_t;

   typedef struct packed {
      gps_pkg::track_rec_t      rec;
      logic [`PWR_W-1:0]        pe, pp, pl;
      logic [`DPHI_W-1:0]       dphi_before;
      logic signed [`TAU_W-1:0] tau_before;
      logic                     carrier_en, code_en;
   } result_t;

   typedef struct packed {
      gps_pkg::mem_addr_t  addr;
      gps_pkg::track_rec_t rec;
   } rd_req_t;

   logic                        clk;
   logic                        i_rst_n;
   logic                        i_clk_sample;
   logic                        i_sample_valid;
   logic signed [`SAMPLE_W-1:0] i_data_i;
   logic signed [`SAMPLE_W-1:0] i_data_q;
   logic                        i_init;
   logic [`PRN_W-1:0]           i_prn;
   logic [`DPHI_W-1:0]          i_init_carrier_dphi;
   logic                        i_track_carrier_en;
   logic                        i_track_code_en;
   gps_pkg::mem_addr_t          i_rd_addr;
   logic                        o_acc_valid;
   logic [1:0]                  o_acc_tag;
   gps_pkg::acc_t               o_i_early, o_q_early;
   gps_pkg::acc_t               o_i_prompt, o_q_prompt;
   gps_pkg::acc_t               o_i_late, o_q_late;
   logic                        o_tracking_ready;
   logic [`PWR_W-1:0]           o_i2q2_early, o_i2q2_prompt, o_i2q2_late;
   logic [`DPHI_W-1:0]          o_carrier_dphi;
   logic signed [`TAU_W-1:0]    o_tau_prime;
   gps_pkg::track_rec_t         o_rd_data;

   // Reference model state.
   integer                   seed;
   logic                     m_active;
   logic [`LFSR_W-1:0]       m_lfsr;
   logic                     m_late;
   int                       m_cnt;
   logic [1:0]               m_tag;
   dump_t                    m_sum;
   int                       dumps_done;
   logic [`DPHI_W-1:0]       dphi_m;
   logic signed [`TAU_W-1:0] tau_m;
   logic                     inited;
   int                       dumps_checked;
   int                       results_checked;
   logic                     reader_busy;
   dump_t                    exp_dumps[$];
   result_t                  exp_results[$];
   rd_req_t                  read_q[$];

   gps_track_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("Watchdog expired before the test sequence finished");
   end

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("error at %0t ns: %s", $time, msg));
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // Taps 10 and 3 with the new bit shifted in at the bottom.
   function automatic logic [`LFSR_W-1:0] lfsr_step(input logic [`LFSR_W-1:0] s);
      return {s[`LFSR_W-2:0], s[`LFSR_W-1] ^ s[2]};
   endfunction

   function automatic int chip_val(input logic chip, input int x);
      return chip ? x : -x;
   endfunction

   function automatic logic [`PWR_W-1:0] tap_power(input int re, input int im);
      longint sq;
      sq = longint'(re) * re + longint'(im) * im;
      return `PWR_W'(sq);
   endfunction

   task automatic model_init();
      m_active = 1'b1;
      m_lfsr   = (i_prn == '0) ? `LFSR_W'(1) : `LFSR_W'(i_prn);
      m_late   = 1'b0;
      m_cnt    = 0;
      m_tag    = 2'd0;
      m_sum    = '0;
   endtask

   task automatic model_sample(input logic valid, input logic signed [`SAMPLE_W-1:0] di,
                               input logic signed [`SAMPLE_W-1:0] dq);
      logic [`LFSR_W-1:0] nxt;
      logic               early;
      logic               prompt;
      if (m_active && valid) begin
         nxt    = lfsr_step(m_lfsr);
         prompt = m_lfsr[`LFSR_W-1];
         early  = nxt[`LFSR_W-1];
         m_sum.ie += chip_val(early, di);
         m_sum.qe += chip_val(early, dq);
         m_sum.ip += chip_val(prompt, di);
         m_sum.qp += chip_val(prompt, dq);
         m_sum.il += chip_val(m_late, di);
         m_sum.ql += chip_val(m_late, dq);
         m_late = prompt;
         m_lfsr = nxt;
         m_cnt++;
         if (m_cnt == `DUMP_LEN) begin
            m_sum.tag = m_tag;
            exp_dumps.push_back(m_sum);
            m_sum = '0;
            m_cnt = 0;
            m_tag = m_tag + 2'd1;
            dumps_done++;
         end
      end
   endtask

   task automatic queue_read(input gps_pkg::mem_addr_t addr, input gps_pkg::track_rec_t rec);
      rd_req_t rq;
      rq.addr = addr;
      rq.rec  = rec;
      read_q.push_back(rq);
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic draw_sample(output logic valid, output logic signed [`SAMPLE_W-1:0] di,
                              output logic signed [`SAMPLE_W-1:0] dq);
      logic [31:0] r;
      r     = $random(seed);
      valid = (r[2:0] != 3'd0);
      di    = r[4:3];
      dq    = r[6:5];
   endtask

   // One sample clock period entered 1 ns after a rising clk edge.
   task automatic send_sample(input logic valid, input logic signed [`SAMPLE_W-1:0] di,
                              input logic signed [`SAMPLE_W-1:0] dq, input logic with_init);
      int c;
      for (c = 0; c < 2 * HALF_SAMPLE; c++) begin
         if (c == 0) begin
            i_clk_sample   = 1'b1;
            i_sample_valid = valid;
            i_data_i       = di;
            i_data_q       = dq;
            model_sample(valid, di, dq);
         end else if (c == HALF_SAMPLE) begin
            i_clk_sample = 1'b0;
         end
         i_init = with_init && (c == INIT_CYCLE);
         if (with_init && c == INIT_CYCLE) begin
            model_init();
         end
         @(posedge clk);
         #1;
      end
   endtask

   // Runs until n more dumps; optionally inits right after the last one.
   task automatic run_dumps(input int n, input logic init_at_end);
      int                          target;
      logic                        valid;
      logic                        last;
      logic signed [`SAMPLE_W-1:0] di;
      logic signed [`SAMPLE_W-1:0] dq;
      target = dumps_done + n;
      while (dumps_done < target) begin
         draw_sample(valid, di, dq);
         last = valid && m_active && (m_cnt == `DUMP_LEN - 1) && (dumps_done == target - 1);
         send_sample(valid, di, dq, init_at_end && last);
      end
   endtask

   initial begin : stimulus
      logic                        valid;
      logic signed [`SAMPLE_W-1:0] di;
      logic signed [`SAMPLE_W-1:0] dq;
      i_rst_n             = 1'b0;
      i_clk_sample        = 1'b0;
      i_sample_valid      = 1'b0;
      i_data_i            = '0;
      i_data_q            = '0;
      i_init              = 1'b0;
      i_prn               = '0;
      i_init_carrier_dphi = '0;
      i_track_carrier_en  = 1'b1;
      i_track_code_en     = 1'b1;
      seed                = 32'h8859_70d7;
      m_active            = 1'b0;
      m_cnt               = 0;
      m_tag               = 2'd0;
      m_sum               = '0;
      dumps_done          = 0;
      repeat (16) @(posedge clk);
      #1;
      i_rst_n = 1'b1;
      for (int a = 0; a < `MEM_DEPTH; a++) begin
         queue_read(gps_pkg::mem_addr_t'(a), '0);
      end
      // Samples before the first init are ignored.
      repeat (20) begin
         draw_sample(valid, di, dq);
         send_sample(valid, di, dq, 1'b0);
      end
      i_prn               = 5'd19;
      i_init_carrier_dphi = 24'h01_4e3c;
      draw_sample(valid, di, dq);
      send_sample(valid, di, dq, 1'b1);
      run_dumps(4, 1'b0);
      i_track_carrier_en = 1'b0;
      run_dumps(2, 1'b0);
      i_track_carrier_en = 1'b1;
      i_track_code_en    = 1'b0;
      // Re-init lands on the loops' result write. PRN 0 maps to seed 1.
      i_prn               = 5'd0;
      i_init_carrier_dphi = 24'hff_fff8;
      run_dumps(2, 1'b1);
      i_track_code_en = 1'b1;
      run_dumps(2, 1'b0);
      repeat (30) @(posedge clk);
      if (exp_dumps.size() == 0 && exp_results.size() == 0 && read_q.size() == 0 &&
          !reader_busy && dumps_checked == dumps_done && results_checked == dumps_done) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         abort_run("Run ended with dumps, results or memory reads still outstanding");
      end
   end

   ////////////////////
   // Checking
   ////////////////////

   initial begin : check_outputs
      dump_t               ed;
      result_t             er;
      longint              prod;
      gps_pkg::track_rec_t init_rec;
      inited          = 1'b0;
      dumps_checked   = 0;
      results_checked = 0;
      wait (i_rst_n === 1'b1);
      forever begin
         @(negedge clk);
         if (!inited) begin
            assert (o_acc_valid === 1'b0 && o_tracking_ready === 1'b0)
               else report_mismatch("dump or ready pulse before init");
         end
         if (i_init) begin
            inited = 1'b1;
            dphi_m = i_init_carrier_dphi;
            tau_m  = '0;
            init_rec.tag          = 2'd0;
            init_rec.carrier_dphi = i_init_carrier_dphi;
            init_rec.tau          = '0;
            queue_read('0, init_rec);
         end
         if (o_acc_valid) begin
            assert (exp_dumps.size() > 0)
               else abort_run("DUT dumped with no dump expected by the model");
            ed = exp_dumps.pop_front();
            assert (o_acc_tag == ed.tag && int'(o_i_early) == ed.ie && int'(o_q_early) == ed.qe &&
                    int'(o_i_prompt) == ed.ip && int'(o_q_prompt) == ed.qp &&
                    int'(o_i_late) == ed.il && int'(o_q_late) == ed.ql)
               else report_mismatch({
                  $sformatf("dump tag %0d E %0d/%0d P %0d/%0d L %0d/%0d",
                     o_acc_tag, o_i_early, o_q_early, o_i_prompt, o_q_prompt,
                     o_i_late, o_q_late),
                  $sformatf(", expected tag %0d E %0d/%0d P %0d/%0d L %0d/%0d",
                     ed.tag, ed.ie, ed.qe, ed.ip, ed.qp, ed.il, ed.ql)});
            er.pe          = tap_power(ed.ie, ed.qe);
            er.pp          = tap_power(ed.ip, ed.qp);
            er.pl          = tap_power(ed.il, ed.ql);
            er.dphi_before = dphi_m;
            er.tau_before  = tau_m;
            er.carrier_en  = i_track_carrier_en;
            er.code_en     = i_track_code_en;
            prod = longint'(ed.ip) * ed.qp;
            if (er.carrier_en && prod > 0) begin
               dphi_m = dphi_m + `DPHI_W'(`CARRIER_STEP);
            end else if (er.carrier_en && prod < 0) begin
               dphi_m = dphi_m - `DPHI_W'(`CARRIER_STEP);
            end
            // Early stronger means the code runs late.
            if (er.code_en && er.pe > er.pl) begin
               tau_m = tau_m - `TAU_W'(1);
            end else if (er.code_en && er.pl > er.pe) begin
               tau_m = tau_m + `TAU_W'(1);
            end
            er.rec.tag          = ed.tag;
            er.rec.carrier_dphi = dphi_m;
            er.rec.tau          = tau_m;
            exp_results.push_back(er);
            dumps_checked++;
         end
         if (o_tracking_ready) begin
            assert (exp_results.size() > 0)
               else abort_run("Tracking result reported with no dump behind it");
            er = exp_results.pop_front();
            assert (o_i2q2_early == er.pe && o_i2q2_prompt == er.pp && o_i2q2_late == er.pl)
               else report_mismatch($sformatf("powers %0d %0d %0d, expected %0d %0d %0d",
                  o_i2q2_early, o_i2q2_prompt, o_i2q2_late, er.pe, er.pp, er.pl));
            if (!er.carrier_en) begin
               assert (o_carrier_dphi == er.dphi_before)
                  else report_mismatch("carrier increment moved with its loop disabled");
            end
            if (!er.code_en) begin
               assert (o_tau_prime == er.tau_before)
                  else report_mismatch("code offset moved with its loop disabled");
            end
            assert (o_carrier_dphi == er.rec.carrier_dphi && o_tau_prime == er.rec.tau)
               else report_mismatch($sformatf("carrier %h offset %0d, expected %h offset %0d",
                  o_carrier_dphi, o_tau_prime, er.rec.carrier_dphi, er.rec.tau));
            queue_read(gps_pkg::mem_addr_t'(er.rec.tag), er.rec);
            results_checked++;
         end
      end
   end

   // Memory reads one at a time once the write has landed.
   initial begin : read_memory
      rd_req_t rq;
      i_rd_addr   = '0;
      reader_busy = 1'b0;
      forever begin
         while (read_q.size() == 0) begin
            @(negedge clk);
         end
         reader_busy = 1'b1;
         rq = read_q.pop_front();
         @(posedge clk);
         @(posedge clk);
         #1;
         i_rd_addr = rq.addr;
         @(negedge clk);
         assert (o_rd_data === rq.rec)
            else report_mismatch($sformatf("memory[%0d] reads %h, expected %h",
               rq.addr, o_rd_data, rq.rec));
         reader_busy = 1'b0;
      end
   end

endmodule

// File: tb.f
+incdir+source
source/gps_pkg.sv
source/sample_sync.sv
source/code_gen.sv
source/correlator_channel.sv
source/tracking_loops.sv
source/track_mem_arbiter.sv
source/gps_track_top.sv
verif/gps_track_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the tracking testbench with Verilator and run it.
# The exit status is the simulator's own.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
   --top-module gps_track_tb \
   -f tb.f \
   -o sim_gps_track \
   && ./obj_dir/sim_gps_track \
   || { echo "Simulation run did not pass"; exit 1; }
